// ==== verilog.f ====
+incdir+testbench
design/biu_ahb_pkg.sv
design/biu_ahb_bridge.sv
design/ahb_sram_slave.sv
design/biu_ahb_subsys.sv
testbench/tb_biu_ahb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, pass only on the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f \
  --top-module tb_biu_ahb -o sim_biu_ahb

out=$(./obj_dir/sim_biu_ahb)
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS"

// ==== testbench/tb_biu_ahb_tasks.svh ====
// BIU driver tasks, reference model helpers, compare tasks, xorshift source
`ifndef TB_BIU_AHB_TASKS_SVH
`define TB_BIU_AHB_TASKS_SVH

//////////////////////////////////////////////////
// random source and reference model

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

function automatic data_t rand_word();
  rng = xorshift32(rng);
  return rng;
endfunction

function automatic int burst_beats(input biu_type_t t);
  case (t)
    WRAP4, INCR4:   return 4;
    WRAP8, INCR8:   return 8;
    WRAP16, INCR16: return 16;
    default:        return 1;  // SINGLE and INCR
  endcase
endfunction

// word step that stays inside the aligned block for wraps
function automatic addr_t expected_next(input addr_t a, input biu_type_t t);
  addr_t blk;  // block size minus one
  case (t)
    WRAP4:   blk = 32'h0f;
    WRAP8:   blk = 32'h1f;
    WRAP16:  blk = 32'h3f;
    default: blk = '1;
  endcase
  return (a & ~blk) | ((a + 32'd4) & blk);
endfunction

function automatic int word_index(input addr_t a);
  return int'((a >> 2) % MEM_WORDS);  // upper windows alias the 1 KiB array
endfunction

// update of the mirror, only the bytes the transfer covers
task automatic ref_write(input addr_t a, input biu_size_t s, input data_t w);
  int nbytes;  // transfer size in bytes
  int first;   // lowest byte of the transfer in the word
  case (s)
    BIU_BYTE:  nbytes = 1;
    BIU_HWORD: nbytes = 2;
    default:   nbytes = 4;
  endcase
  first = (int'(a[1:0]) / nbytes) * nbytes;  // natural alignment
  for (int i = first; i < first + nbytes; i++) begin
    ref_mem[word_index(a)][8*i +: 8] = w[8*i +: 8];
  end
endtask

//////////////////////////////////////////////////
// compare tasks

task automatic check_data(input string name, input data_t got, input data_t exp);
  if (got !== exp) begin
    errors++;
    $display("MISMATCH %s: got %08h expected %08h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_addr(input string name, input addr_t got, input addr_t exp);
  if (got !== exp) begin
    errors++;
    $display("MISMATCH %s: got %08h expected %08h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    errors++;
    $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_count(input string name, input int got, input int exp);
  if (got != exp) begin
    errors++;
    $display("MISMATCH %s: got %0h expected %0h at %0t", name, got, exp, $time);
  end
endtask

task automatic report_timeout(input string what);
  timeouts++;
  $display("timeout: no %s within %0d cycles at %0t", what, TIMEOUT, $time);
endtask

//////////////////////////////////////////////////
// BIU driver

task automatic run_transfer(input logic we, input biu_type_t t, input addr_t a,
                            input biu_size_t s, input logic expect_err);
  addr_t exp_adr;   // address the next ack reports
  data_t cur_d;     // word on biu_d for the coming beat
  data_t wq[$];     // taken by the bridge and awaiting ack
  int    beats;
  int    n_ack;
  int    n_err;
  int    idle;
  logic  prev_ack;
  logic  slow;
  exp_adr  = a;
  beats    = burst_beats(t);
  n_ack    = 0;
  n_err    = 0;
  idle     = 0;
  prev_ack = 1'b0;
  slow     = (a >= SLOW_BASE) && (a < ERR_BASE);
  cur_d    = rand_word();
  biu_stb <= 1'b1;
  biu_req <= '{adr: a, size: s, btype: t, prot: PROT_DATA, lock: 1'b0, we: we};
  biu_d   <= cur_d;

  // request phase
  do begin
    @(posedge HCLK);
    idle++;
  end while (!biu_stb_ack && idle < TIMEOUT);
  biu_stb <= 1'b0;
  if (!biu_stb_ack) begin
    report_timeout("biu_stb_ack_o");
    return;
  end

  // beat loop with the timeout restarted on every handshake
  idle = 0;
  while (n_ack < beats && n_err == 0 && idle < TIMEOUT) begin
    @(posedge HCLK);
    idle++;
    if (biu_d_ack) begin
      wq.push_back(cur_d);  // sampled by the bridge at this edge
      cur_d = rand_word();
      biu_d <= cur_d;
      idle = 0;
    end
    if (biu_ack) begin
      check_addr("biu_adro_o", biu_adro, exp_adr);
      if (slow) check_flag("biu_ack_o after wait state", prev_ack, 1'b0);
      if (!we) begin
        check_data("biu_q_o", biu_q, ref_mem[word_index(exp_adr)]);
      end else if (wq.size() == 0) begin
        errors++;
        $display("write beat acked before its data was taken at %0t", $time);
      end else begin
        ref_write(exp_adr, s, wq.pop_front());
      end
      exp_adr = expected_next(exp_adr, t);
      n_ack++;
      idle = 0;
    end
    if (biu_err) n_err++;
    prev_ack = biu_ack;
  end
  if (n_ack < beats && n_err == 0) report_timeout("biu_ack_o");

  // a few quiet cycles to catch late or extra pulses
  repeat (3) begin
    @(posedge HCLK);
    n_ack += int'(biu_ack);
    n_err += int'(biu_err);
  end
  check_count("biu_err_o pulses", n_err, expect_err ? 1 : 0);
  check_count("biu_ack_o beats", n_ack, expect_err ? 0 : beats);
endtask

task automatic biu_write_burst(input biu_type_t t, input addr_t a, input biu_size_t s,
                               input logic expect_err);
  run_transfer(1'b1, t, a, s, expect_err);
endtask

task automatic biu_read_burst(input biu_type_t t, input addr_t a, input biu_size_t s,
                              input logic expect_err);
  run_transfer(1'b0, t, a, s, expect_err);
endtask

`endif

// ==== testbench/tb_biu_ahb.sv ====
// testbench top with clock, reset, reference memory, directed tests and summary line
`timescale 1ns/1ps
`default_nettype none

module tb_biu_ahb;

  import biu_ahb_pkg::*;

  localparam int TIMEOUT = 64;  // cycles allowed per wait

  //////////////////////////////////////////////////
  // DUT signals
  logic     HCLK;
  logic     HRESETn;
  logic     biu_stb;
  biu_req_t biu_req;
  data_t    biu_d;
  logic     biu_stb_ack;
  logic     biu_d_ack;
  logic     biu_ack;
  logic     biu_err;
  addr_t    biu_adro;
  data_t    biu_q;

  data_t       ref_mem [MEM_WORDS];  // mirror of the slave array
  logic [31:0] rng;                  // xorshift state
  int          errors;
  int          timeouts;

  `include "tb_biu_ahb_tasks.svh"

  biu_ahb_subsys uut (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .biu_stb_i     (biu_stb),
    .biu_req_i     (biu_req),
    .biu_d_i       (biu_d),
    .biu_stb_ack_o (biu_stb_ack),
    .biu_d_ack_o   (biu_d_ack),
    .biu_ack_o     (biu_ack),
    .biu_err_o     (biu_err),
    .biu_adro_o    (biu_adro),
    .biu_q_o       (biu_q)
  );

  initial begin
    HCLK = 1'b0;
    forever #2 HCLK = ~HCLK;  // 4 ns period
  end

  //////////////////////////////////////////////////
  // directed tests

  // every word written once before any byte lane update
  task automatic fill_memory();
    for (int a = 0; a < MEM_WORDS * 4; a += 64) begin
      biu_write_burst(INCR16, addr_t'(a), BIU_WORD, 1'b0);
    end
  endtask

  task automatic test_single_sizes();
    addr_t     adr [3];
    biu_size_t sz [3];
    adr = '{32'h43, 32'h46, 32'h48};  // odd byte, upper half, word
    sz  = '{BIU_BYTE, BIU_HWORD, BIU_WORD};
    for (int i = 0; i < 3; i++) begin
      biu_write_burst(SINGLE, adr[i], sz[i], 1'b0);
      biu_read_burst(SINGLE, {adr[i][31:2], 2'b00}, BIU_WORD, 1'b0);
    end
  endtask

  task automatic test_incr_bursts();
    biu_write_burst(INCR4, 32'h100, BIU_WORD, 1'b0);
    biu_read_burst(INCR4, 32'h100, BIU_WORD, 1'b0);
    biu_write_burst(INCR8, 32'h180, BIU_WORD, 1'b0);
    biu_read_burst(INCR8, 32'h180, BIU_WORD, 1'b0);
  endtask

  // both start mid block so the wrap point is hit
  task automatic test_wrap_bursts();
    biu_write_burst(WRAP4, 32'h208, BIU_WORD, 1'b0);
    biu_read_burst(WRAP4, 32'h208, BIU_WORD, 1'b0);
    biu_write_burst(WRAP8, 32'h2f4, BIU_WORD, 1'b0);
    biu_read_burst(WRAP8, 32'h2f4, BIU_WORD, 1'b0);
  endtask

  task automatic test_wait_states();
    biu_write_burst(INCR4, SLOW_BASE, BIU_WORD, 1'b0);
    biu_read_burst(INCR4, SLOW_BASE, BIU_WORD, 1'b0);
    biu_read_burst(SINGLE, SLOW_BASE + 32'h3c, BIU_WORD, 1'b0);
  endtask

  task automatic test_error_region();
    biu_write_burst(SINGLE, ERR_BASE, BIU_WORD, 1'b1);
    biu_read_burst(INCR4, ERR_BASE, BIU_WORD, 1'b1);
    biu_write_burst(SINGLE, 32'h30, BIU_WORD, 1'b0);  // bus usable again
    biu_read_burst(SINGLE, 32'h30, BIU_WORD, 1'b0);
  endtask

  task automatic test_random_singles();
    logic [31:0] r;
    addr_t       a;
    biu_size_t   sz;
    for (int n = 0; n < 40; n++) begin
      r  = rand_word();
      sz = (r[1:0] == 2'd0) ? BIU_BYTE : (r[1:0] == 2'd1) ? BIU_HWORD : BIU_WORD;
      a  = addr_t'(r[17:8]);  // below SLOW_BASE
      if (sz == BIU_HWORD) a[0] = 1'b0;
      if (sz == BIU_WORD) a[1:0] = 2'b00;
      biu_write_burst(SINGLE, a, sz, 1'b0);
      biu_read_burst(SINGLE, a, sz, 1'b0);  // full word back for any size
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  initial begin
    HRESETn  = 1'b0;
    biu_stb  = 1'b0;
    biu_req  = '0;
    biu_d    = '0;
    rng      = 32'h09d08f1a;
    errors   = 0;
    timeouts = 0;
    repeat (10) @(posedge HCLK);
    HRESETn <= 1'b1;
    @(posedge HCLK);
    check_flag("biu_stb_ack_o", biu_stb_ack, 1'b0);  // all quiet out of reset
    check_flag("biu_d_ack_o", biu_d_ack, 1'b0);
    check_flag("biu_ack_o", biu_ack, 1'b0);
    check_flag("biu_err_o", biu_err, 1'b0);

    fill_memory();
    test_single_sizes();
    test_incr_bursts();
    test_wrap_bursts();
    test_wait_states();
    test_error_region();
    test_random_singles();

    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/biu_ahb_subsys.sv ====
// top level: BIU to AHB-Lite bridge joined to the memory slave, BIU port exposed
`timescale 1ns/1ps
`default_nettype none

module biu_ahb_subsys (
  input  wire logic                  HCLK,
  input  wire logic                  HRESETn,

  // core side BIU port
  input  wire logic                  biu_stb_i,
  input  wire biu_ahb_pkg::biu_req_t biu_req_i,
  input  wire biu_ahb_pkg::data_t    biu_d_i,
  output wire logic                  biu_stb_ack_o,
  output wire logic                  biu_d_ack_o,
  output wire logic                  biu_ack_o,
  output wire logic                  biu_err_o,
  output wire biu_ahb_pkg::addr_t    biu_adro_o,
  output wire biu_ahb_pkg::data_t    biu_q_o
);

  import biu_ahb_pkg::*;

  //////////////////////////////////////////////////
  // internal AHB-Lite bus

  ahb_m2s_t ahb_m2s;  // master to slave
  ahb_s2m_t ahb_s2m;  // slave to master, hready included

  // master
  biu_ahb_bridge u_bridge (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .biu_stb_i     (biu_stb_i),
    .biu_req_i     (biu_req_i),
    .biu_d_i       (biu_d_i),
    .biu_stb_ack_o (biu_stb_ack_o),
    .biu_d_ack_o   (biu_d_ack_o),
    .biu_ack_o     (biu_ack_o),
    .biu_err_o     (biu_err_o),
    .biu_adro_o    (biu_adro_o),
    .biu_q_o       (biu_q_o),
    .ahb_o         (ahb_m2s),
    .ahb_i         (ahb_s2m)
  );

  // the only slave, so no decoder or hready mux
  ahb_sram_slave u_sram (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .ahb_i   (ahb_m2s),
    .ahb_o   (ahb_s2m)
  );

endmodule

`default_nettype wire

// ==== design/ahb_sram_slave.sv ====
// AHB-Lite memory slave: byte lane writes, wait-state window, two-cycle ERROR region
`timescale 1ns/1ps
`default_nettype none

module ahb_sram_slave (
  input  wire logic                  HCLK,
  input  wire logic                  HRESETn,
  input  wire biu_ahb_pkg::ahb_m2s_t ahb_i,
  output biu_ahb_pkg::ahb_s2m_t      ahb_o
);

  import biu_ahb_pkg::*;

  // data phase sequencer
  typedef enum logic [1:0] {
    ST_READY,  // hready high, OKAY
    ST_WAIT,   // slow window, one wait
    ST_ERR1,   // ERROR with hready low
    ST_ERR2    // ERROR with hready high
  } dp_state_e;

  //////////////////////////////////////////////////
  // signals

  data_t     mem [MEM_WORDS];
  dp_state_e state_q;
  dp_state_e state_nxt;  // state for a captured beat, by region
  logic      hready;
  logic      resp;
  logic      addr_valid; // address phase taken this cycle
  logic      addr_slow;
  logic      addr_err;

  // captured address phase
  logic                         dp_act;
  logic                         dp_we;
  logic [$clog2(MEM_WORDS)-1:0] dp_idx;
  logic [XLEN/8-1:0]            dp_lanes;

  // byte lanes from size and low address bits
  function automatic logic [XLEN/8-1:0] lane_mask(hsize_t hsize, logic [1:0] ofs);
    case (hsize)
      HSIZE_BYTE:  return 4'b0001 << ofs;
      HSIZE_HWORD: return ofs[1] ? 4'b1100 : 4'b0011;
      HSIZE_WORD:  return 4'b1111;
      default:     return 4'b1111;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // address phase

  assign addr_valid = ahb_i.hsel && hready &&
                      (ahb_i.htrans == HTRANS_NONSEQ || ahb_i.htrans == HTRANS_SEQ);
  assign addr_err   = (ahb_i.haddr >= ERR_BASE);
  assign addr_slow  = (ahb_i.haddr >= SLOW_BASE) && !addr_err;

  // region class picks the data phase pattern
  always_comb begin
    if (addr_err) begin
      state_nxt = ST_ERR1;
    end else if (addr_slow) begin
      state_nxt = ST_WAIT;
    end else begin
      state_nxt = ST_READY;
    end
  end

  always_ff @(posedge HCLK) begin
    if (addr_valid) begin
      dp_idx   <= ahb_i.haddr[$clog2(MEM_WORDS)+1:2];  // slow window aliases the array
      dp_we    <= ahb_i.hwrite;
      dp_lanes <= lane_mask(ahb_i.hsize, ahb_i.haddr[1:0]);
    end
  end

  //////////////////////////////////////////////////
  // wait and error sequencer

  always_ff @(posedge HCLK, negedge HRESETn) begin
    if (!HRESETn) begin
      state_q <= ST_READY;
      dp_act  <= 1'b0;
    end else begin
      case (state_q)
        ST_WAIT: state_q <= ST_READY;  // slow beat completes next
        ST_ERR1: state_q <= ST_ERR2;
        default: state_q <= addr_valid ? state_nxt : ST_READY;
      endcase
      if (hready) begin
        dp_act <= addr_valid;
      end
    end
  end

  assign hready = (state_q == ST_READY) || (state_q == ST_ERR2);
  assign resp   = (state_q == ST_ERR1) || (state_q == ST_ERR2) ? HRESP_ERROR : HRESP_OKAY;

  //////////////////////////////////////////////////
  // memory

  // write at the end of an OKAY data phase, selected lanes only
  always_ff @(posedge HCLK) begin
    if (dp_act && dp_we && state_q == ST_READY) begin
      for (int i = 0; i < XLEN/8; i++) begin
        if (dp_lanes[i]) begin
          mem[dp_idx][8*i +: 8] <= ahb_i.hwdata[8*i +: 8];
        end
      end
    end
  end

  // full word back for any size
  assign ahb_o = '{
    hrdata: mem[dp_idx],
    hready: hready,
    hresp:  resp
  };

endmodule

`default_nettype wire

// ==== design/biu_ahb_bridge.sv ====
// BIU to AHB-Lite master bridge: burst counter, address sequencer, error abort, data pipeline
`timescale 1ns/1ps
`default_nettype none

module biu_ahb_bridge (
  input  wire logic                  HCLK,
  input  wire logic                  HRESETn,

  // core side
  input  wire logic                  biu_stb_i,      // request, held until stb_ack
  input  wire biu_ahb_pkg::biu_req_t biu_req_i,
  input  wire biu_ahb_pkg::data_t    biu_d_i,        // write data, valid in d_ack cycle
  output logic                       biu_stb_ack_o,  // request taken
  output logic                       biu_d_ack_o,    // beat address phase on the bus
  output logic                       biu_ack_o,      // beat data phase done
  output logic                       biu_err_o,      // error pulse
  output biu_ahb_pkg::addr_t         biu_adro_o,     // address of the acked beat
  output biu_ahb_pkg::data_t         biu_q_o,        // read data, valid with ack

  // AHB-Lite side
  output biu_ahb_pkg::ahb_m2s_t      ahb_o,
  input  wire biu_ahb_pkg::ahb_s2m_t ahb_i
);

  import biu_ahb_pkg::*;

  //////////////////////////////////////////////////
  // signals

  beat_cnt_t burst_cnt;    // beats left after the one on the bus
  logic      burst_done;
  logic      step;         // issue next SEQ beat
  logic      abort;        // first cycle of an ERROR response
  logic      data_ena;     // address phase on bus belongs to a beat
  logic      data_ena_d;   // data phase on bus belongs to a beat

  // address phase
  logic      hsel_q;
  htrans_e   htrans_q;
  logic      hmastlock_q;
  addr_t     haddr_q;
  logic      hwrite_q;
  hsize_t    hsize_q;
  hburst_t   hburst_q;
  hprot_t    hprot_q;

  // data phase
  data_t     hwdata_q;

  assign burst_done = (burst_cnt == '0);
  assign step       = ahb_i.hready && !burst_done;
  assign abort      = !ahb_i.hready && (ahb_i.hresp == HRESP_ERROR);

  // new request only between bursts, not in the err pulse cycle
  assign biu_stb_ack_o = ahb_i.hready & burst_done & biu_stb_i & ~biu_err_o;

  //////////////////////////////////////////////////
  // burst sequencer

  always_ff @(posedge HCLK, negedge HRESETn) begin
    if (!HRESETn) begin
      burst_cnt   <= '0;
      data_ena    <= 1'b0;
      data_ena_d  <= 1'b0;
      hsel_q      <= 1'b0;
      htrans_q    <= HTRANS_IDLE;
      hmastlock_q <= 1'b0;
      biu_err_o   <= 1'b0;
    end else begin
      biu_err_o <= abort;  // reported in the 2nd error cycle

      if (abort) begin
        // drop the rest of the burst, IDLE in the 2nd error cycle
        burst_cnt  <= '0;
        data_ena   <= 1'b0;
        data_ena_d <= 1'b0;  // failed beat never acked
        hsel_q     <= 1'b0;
        htrans_q   <= HTRANS_IDLE;
      end else if (ahb_i.hready) begin
        data_ena_d <= data_ena;  // address phase moves into data phase

        if (biu_stb_ack_o) begin
          burst_cnt   <= type_to_cnt(biu_req_i.btype);
          data_ena    <= 1'b1;
          hsel_q      <= 1'b1;
          htrans_q    <= HTRANS_NONSEQ;  // first beat
          hmastlock_q <= biu_req_i.lock;
        end else if (step) begin
          burst_cnt <= burst_cnt - beat_cnt_t'(1);
          data_ena  <= 1'b1;
          htrans_q  <= HTRANS_SEQ;
        end else begin
          data_ena    <= 1'b0;
          hsel_q      <= 1'b0;
          htrans_q    <= HTRANS_IDLE;
          hmastlock_q <= biu_req_i.lock;  // lock follows the core when idle
        end
      end
    end
  end

  // address and attributes of the beat, payload only
  always_ff @(posedge HCLK) begin
    if (biu_stb_ack_o) begin
      haddr_q  <= biu_req_i.adr;
      hwrite_q <= biu_req_i.we;
      hsize_q  <= size_to_hsize(biu_req_i.size);
      hburst_q <= type_to_hburst(biu_req_i.btype);
      hprot_q  <= prot_to_hprot(biu_req_i.prot);
    end else if (step) begin
      haddr_q  <= next_beat_addr(haddr_q, hburst_q);  // incr or wrap
    end
  end

  //////////////////////////////////////////////////
  // data side

  // per beat handshakes, both only on hready
  assign biu_d_ack_o = ahb_i.hready & data_ena;
  assign biu_ack_o   = ahb_i.hready & data_ena_d;

  // write data and beat address move with the address phase
  always_ff @(posedge HCLK) begin
    if (biu_d_ack_o) begin
      hwdata_q   <= biu_d_i;   // held through wait states
      biu_adro_o <= haddr_q;
    end
  end

  assign biu_q_o = ahb_i.hrdata;

  //////////////////////////////////////////////////
  // bus outputs

  assign ahb_o = '{
    hsel:      hsel_q,
    haddr:     haddr_q,
    hwrite:    hwrite_q,
    hsize:     hsize_q,
    hburst:    hburst_q,
    hprot:     hprot_q,
    htrans:    htrans_q,
    hmastlock: hmastlock_q,
    hwdata:    hwdata_q
  };

endmodule

`default_nettype wire

// ==== design/biu_ahb_pkg.sv ====
// widths, BIU and AHB-Lite encodings, bus structs, BIU to AHB conversion functions
`default_nettype none

package biu_ahb_pkg;

  //////////////////////////////////////////////////
  // widths and memory map
  localparam int unsigned XLEN      = 32;
  localparam int unsigned PLEN      = 32;
  localparam int unsigned MEM_WORDS = 256;      // 1 KiB slave array
  localparam logic [31:0] SLOW_BASE = 32'h400;  // one wait state per beat from here
  localparam logic [31:0] ERR_BASE  = 32'h800;  // ERROR response from here up

  typedef logic [PLEN-1:0] addr_t;
  typedef logic [XLEN-1:0] data_t;
  typedef logic [2:0]      biu_size_t;
  typedef logic [2:0]      biu_type_t;
  typedef logic [2:0]      biu_prot_t;
  typedef logic [2:0]      hsize_t;
  typedef logic [2:0]      hburst_t;
  typedef logic [3:0]      hprot_t;
  typedef logic [3:0]      beat_cnt_t;  // beats left minus one

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  //////////////////////////////////////////////////
  // core side encodings
  localparam biu_size_t BIU_BYTE  = 3'b000;
  localparam biu_size_t BIU_HWORD = 3'b001;
  localparam biu_size_t BIU_WORD  = 3'b010;

  localparam biu_type_t SINGLE = 3'd0;
  localparam biu_type_t INCR   = 3'd1;
  localparam biu_type_t WRAP4  = 3'd2;
  localparam biu_type_t INCR4  = 3'd3;
  localparam biu_type_t WRAP8  = 3'd4;
  localparam biu_type_t INCR8  = 3'd5;
  localparam biu_type_t WRAP16 = 3'd6;
  localparam biu_type_t INCR16 = 3'd7;

  localparam biu_prot_t PROT_DATA       = 3'b001;  // else opcode fetch
  localparam biu_prot_t PROT_PRIVILEGED = 3'b010;
  localparam biu_prot_t PROT_CACHEABLE  = 3'b100;

  //////////////////////////////////////////////////
  // AHB-Lite encodings
  localparam hsize_t HSIZE_BYTE  = 3'b000;
  localparam hsize_t HSIZE_HWORD = 3'b001;
  localparam hsize_t HSIZE_WORD  = 3'b010;

  localparam hburst_t HBURST_SINGLE = 3'b000;
  localparam hburst_t HBURST_INCR   = 3'b001;
  localparam hburst_t HBURST_WRAP4  = 3'b010;
  localparam hburst_t HBURST_INCR4  = 3'b011;
  localparam hburst_t HBURST_WRAP8  = 3'b100;
  localparam hburst_t HBURST_INCR8  = 3'b101;
  localparam hburst_t HBURST_WRAP16 = 3'b110;
  localparam hburst_t HBURST_INCR16 = 3'b111;

  localparam hprot_t HPROT_OPCODE        = 4'b0000;
  localparam hprot_t HPROT_DATA          = 4'b0001;
  localparam hprot_t HPROT_USER          = 4'b0000;
  localparam hprot_t HPROT_PRIVILEGED    = 4'b0010;
  localparam hprot_t HPROT_NON_CACHEABLE = 4'b0000;
  localparam hprot_t HPROT_CACHEABLE     = 4'b1000;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  //////////////////////////////////////////////////
  // bus structs
  typedef struct packed {
    addr_t     adr;
    biu_size_t size;
    biu_type_t btype;
    biu_prot_t prot;
    logic      lock;
    logic      we;
  } biu_req_t;

  typedef struct packed {
    logic    hsel;
    addr_t   haddr;
    logic    hwrite;
    hsize_t  hsize;
    hburst_t hburst;
    hprot_t  hprot;
    htrans_e htrans;
    logic    hmastlock;
    data_t   hwdata;
  } ahb_m2s_t;

  typedef struct packed {
    data_t hrdata;
    logic  hready;
    logic  hresp;
  } ahb_s2m_t;

  //////////////////////////////////////////////////
  // conversions
  function automatic hsize_t size_to_hsize(biu_size_t size);
    case (size)
      BIU_BYTE:  return HSIZE_BYTE;
      BIU_HWORD: return HSIZE_HWORD;
      BIU_WORD:  return HSIZE_WORD;
      default:   return HSIZE_WORD;  // nothing wider on a 32 bit bus
    endcase
  endfunction

  function automatic beat_cnt_t type_to_cnt(biu_type_t btype);
    case (btype)
      WRAP4, INCR4:   return 4'd3;
      WRAP8, INCR8:   return 4'd7;
      WRAP16, INCR16: return 4'd15;
      default:        return 4'd0;  // SINGLE, INCR as one beat
    endcase
  endfunction

  function automatic hburst_t type_to_hburst(biu_type_t btype);
    case (btype)
      SINGLE:  return HBURST_SINGLE;
      INCR:    return HBURST_INCR;
      WRAP4:   return HBURST_WRAP4;
      INCR4:   return HBURST_INCR4;
      WRAP8:   return HBURST_WRAP8;
      INCR8:   return HBURST_INCR8;
      WRAP16:  return HBURST_WRAP16;
      default: return HBURST_INCR16;
    endcase
  endfunction

  function automatic hprot_t prot_to_hprot(biu_prot_t prot);
    hprot_t hp;
    hp = |(prot & PROT_DATA) ? HPROT_DATA : HPROT_OPCODE;
    hp = hp | (|(prot & PROT_PRIVILEGED) ? HPROT_PRIVILEGED : HPROT_USER);
    hp = hp | (|(prot & PROT_CACHEABLE) ? HPROT_CACHEABLE : HPROT_NON_CACHEABLE);
    return hp;
  endfunction

  // next word address, wrap keeps the upper bits of the aligned block
  function automatic addr_t next_beat_addr(addr_t addr, hburst_t hburst);
    addr_t nxt;
    nxt = (addr + addr_t'(4)) & ~addr_t'(3);
    case (hburst)
      HBURST_WRAP4:  nxt = {addr[PLEN-1:4], nxt[3:0]};  // 16 byte block
      HBURST_WRAP8:  nxt = {addr[PLEN-1:5], nxt[4:0]};  // 32 byte block
      HBURST_WRAP16: nxt = {addr[PLEN-1:6], nxt[5:0]};  // 64 byte block
      default: ;
    endcase
    return nxt;
  endfunction

endpackage

`default_nettype wire
